// File: common/fcpu_pkg.sv
package fcpu_pkg;

   // datapath widths
   localparam int DATA_W     = 16;
   localparam int TAG_W      = 4;
   localparam int INSTR_W    = 4;
   localparam int N_OPERANDS = 3;

   // station size
   localparam int RS_DEPTH_W = 2;
   localparam int RS_DEPTH   = 2 ** RS_DEPTH_W;

   // cdb word is tag over data
   localparam int CDB_W = TAG_W + DATA_W;

   // issued branch as held in the pre-calculation buffer
   localparam int CALC_W = INSTR_W + TAG_W + N_OPERANDS * DATA_W;

   typedef enum logic [INSTR_W-1:0] {
      I_NOP,
      I_BLT,
      I_BEQ,
      I_JMP,
      I_JMPR
   } opcode_t;

   typedef enum logic [1:0] {
      S_FREE,
      S_WAIT,
      S_READY
   } slot_state_t;

endpackage

// File: src/fifo.sv
module fifo #(
   parameter int DEPTH_W = 0,
   parameter int WIDTH   = 8
) (
   input  logic             clk,
   input  logic             i_reset,
   input  logic             i_flush,
   input  logic [WIDTH-1:0] i_data,
   input  logic             i_valid,
   output logic             o_ready,
   output logic [WIDTH-1:0] o_data,
   output logic             o_valid,
   input  logic             i_ready
);

   localparam int DEPTH = 2 ** DEPTH_W;
   localparam int PTR_W = (DEPTH_W == 0) ? 1 : DEPTH_W;

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [DEPTH_W:0] count;
   logic             push;
   logic             pop;

   // a full buffer still takes an item when its head leaves
   assign o_valid = (count != '0);
   assign o_ready = (count != (DEPTH_W + 1)'(DEPTH)) || i_ready;
   assign o_data  = mem[rd_ptr];
   assign push    = i_valid && o_ready;
   assign pop     = o_valid && i_ready;

   always_ff @(posedge clk) begin
      if (i_reset || i_flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= i_data;
      end
   end

endmodule

// File: src/cdb_arbiter.sv
module cdb_arbiter (
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_alu_valid,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_alu_tag,
   input  logic [fcpu_pkg::DATA_W-1:0] i_alu_data,
   output logic                        o_alu_ready,
   input  logic                        i_br_valid,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_br_tag,
   input  logic [fcpu_pkg::DATA_W-1:0] i_br_data,
   output logic                        o_br_ready,
   output logic                        o_cdb_valid,
   output logic [fcpu_pkg::TAG_W-1:0]  o_cdb_tag,
   output logic [fcpu_pkg::DATA_W-1:0] o_cdb_data
);

   logic                       last_br;
   logic                       alu_fire;
   logic                       br_fire;
   logic [fcpu_pkg::CDB_W-1:0] cdb_q;

   // on conflict the source not granted last time wins
   assign o_alu_ready = !i_br_valid || last_br;
   assign o_br_ready  = !i_alu_valid || !last_br;
   assign alu_fire    = i_alu_valid && o_alu_ready;
   assign br_fire     = i_br_valid && o_br_ready;

   assign o_cdb_tag  = cdb_q[fcpu_pkg::CDB_W-1 -: fcpu_pkg::TAG_W];
   assign o_cdb_data = cdb_q[fcpu_pkg::DATA_W-1:0];

   always_ff @(posedge clk) begin
      if (i_reset) begin
         last_br     <= 1'b0;
         o_cdb_valid <= 1'b0;
      end else begin
         o_cdb_valid <= alu_fire || br_fire;
         if (alu_fire) begin
            last_br <= 1'b0;
         end else if (br_fire) begin
            last_br <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (alu_fire) begin
         cdb_q <= {i_alu_tag, i_alu_data};
      end else if (br_fire) begin
         cdb_q <= {i_br_tag, i_br_data};
      end
   end

endmodule

// File: branch_unit/reservation_station.sv
module reservation_station (
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_flush,
   input  logic                        i_disp_valid,
   input  fcpu_pkg::opcode_t           i_disp_opcode,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_disp_tag,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_a1_tag,
   input  logic [fcpu_pkg::DATA_W-1:0] i_a1_value,
   input  logic                        i_a1_filled,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_a2_tag,
   input  logic [fcpu_pkg::DATA_W-1:0] i_a2_value,
   input  logic                        i_a2_filled,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_dst_tag,
   input  logic [fcpu_pkg::DATA_W-1:0] i_dst_value,
   input  logic                        i_dst_filled,
   input  logic                        i_cdb_valid,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_cdb_tag,
   input  logic [fcpu_pkg::DATA_W-1:0] i_cdb_data,
   input  logic                        i_issue_ready,
   output logic                        o_disp_ready,
   output logic                        o_issue_valid,
   output fcpu_pkg::opcode_t           o_issue_opcode,
   output logic [fcpu_pkg::TAG_W-1:0]  o_issue_tag,
   output logic [fcpu_pkg::DATA_W-1:0] o_issue_a1,
   output logic [fcpu_pkg::DATA_W-1:0] o_issue_a2,
   output logic [fcpu_pkg::DATA_W-1:0] o_issue_dst
);

   fcpu_pkg::slot_state_t              state    [fcpu_pkg::RS_DEPTH];
   fcpu_pkg::opcode_t                  slot_op  [fcpu_pkg::RS_DEPTH];
   logic [fcpu_pkg::TAG_W-1:0]         slot_tag [fcpu_pkg::RS_DEPTH];
   logic [fcpu_pkg::TAG_W-1:0]  op_tag [fcpu_pkg::RS_DEPTH][fcpu_pkg::N_OPERANDS];
   logic [fcpu_pkg::DATA_W-1:0] op_val [fcpu_pkg::RS_DEPTH][fcpu_pkg::N_OPERANDS];
   logic [fcpu_pkg::N_OPERANDS-1:0]    filled   [fcpu_pkg::RS_DEPTH];
   logic [fcpu_pkg::N_OPERANDS-1:0]    hit      [fcpu_pkg::RS_DEPTH];
   logic [fcpu_pkg::RS_DEPTH_W-1:0]    head;
   logic [fcpu_pkg::RS_DEPTH_W-1:0]    tail;
   logic [fcpu_pkg::TAG_W-1:0]         disp_tag [fcpu_pkg::N_OPERANDS];
   logic [fcpu_pkg::DATA_W-1:0]        disp_val [fcpu_pkg::N_OPERANDS];
   logic [fcpu_pkg::N_OPERANDS-1:0]    disp_filled;
   logic [fcpu_pkg::N_OPERANDS-1:0]    disp_now;
   logic                               disp_fire;
   logic                               issue_fire;

   // operand 0 is a1, 1 is a2, 2 is dst
   assign disp_tag    = '{i_a1_tag, i_a2_tag, i_dst_tag};
   assign disp_val    = '{i_a1_value, i_a2_value, i_dst_value};
   assign disp_filled = {i_dst_filled, i_a2_filled, i_a1_filled};

   // head is the oldest entry, tail the next free one
   assign o_disp_ready  = (state[tail] == fcpu_pkg::S_FREE) && !i_flush;
   assign o_issue_valid = (state[head] == fcpu_pkg::S_READY);
   assign disp_fire     = i_disp_valid && o_disp_ready;
   assign issue_fire    = o_issue_valid && i_issue_ready;

   assign o_issue_opcode = slot_op[head];
   assign o_issue_tag    = slot_tag[head];
   assign o_issue_a1     = op_val[head][0];
   assign o_issue_a2     = op_val[head][1];
   assign o_issue_dst    = op_val[head][2];

   // cdb snoop, also on the dispatch cycle itself
   always_comb begin
      for (int k = 0; k < fcpu_pkg::N_OPERANDS; k++) begin
         disp_now[k] = disp_filled[k] || (i_cdb_valid && disp_tag[k] == i_cdb_tag);
      end
      for (int i = 0; i < fcpu_pkg::RS_DEPTH; i++) begin
         for (int k = 0; k < fcpu_pkg::N_OPERANDS; k++) begin
            hit[i][k] = i_cdb_valid && state[i] == fcpu_pkg::S_WAIT && !filled[i][k]
                        && op_tag[i][k] == i_cdb_tag;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset || i_flush) begin
         for (int i = 0; i < fcpu_pkg::RS_DEPTH; i++) begin
            state[i]  <= fcpu_pkg::S_FREE;
            filled[i] <= '0;
         end
         head <= '0;
         tail <= '0;
      end else begin
         for (int i = 0; i < fcpu_pkg::RS_DEPTH; i++) begin
            if (state[i] == fcpu_pkg::S_WAIT) begin
               filled[i] <= filled[i] | hit[i];
               if (&(filled[i] | hit[i])) begin
                  state[i] <= fcpu_pkg::S_READY;
               end
            end
         end
         if (issue_fire) begin
            state[head] <= fcpu_pkg::S_FREE;
            head        <= head + 1'b1;
         end
         if (disp_fire) begin
            filled[tail] <= disp_now;
            state[tail]  <= (&disp_now) ? fcpu_pkg::S_READY : fcpu_pkg::S_WAIT;
            tail         <= tail + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < fcpu_pkg::RS_DEPTH; i++) begin
         for (int k = 0; k < fcpu_pkg::N_OPERANDS; k++) begin
            if (hit[i][k]) begin
               op_val[i][k] <= i_cdb_data;
            end
         end
      end
      if (disp_fire) begin
         slot_op[tail]  <= i_disp_opcode;
         slot_tag[tail] <= i_disp_tag;
         for (int k = 0; k < fcpu_pkg::N_OPERANDS; k++) begin
            op_tag[tail][k] <= disp_tag[k];
            op_val[tail][k] <= disp_filled[k] ? disp_val[k] : i_cdb_data;
         end
      end
   end

endmodule

// File: branch_unit/branch_unit.sv
module branch_unit (
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_disp_valid,
   input  fcpu_pkg::opcode_t           i_disp_opcode,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_disp_tag,
   input  logic                        i_disp_pred,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_a1_tag,
   input  logic [fcpu_pkg::DATA_W-1:0] i_a1_value,
   input  logic                        i_a1_filled,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_a2_tag,
   input  logic [fcpu_pkg::DATA_W-1:0] i_a2_value,
   input  logic                        i_a2_filled,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_dst_tag,
   input  logic [fcpu_pkg::DATA_W-1:0] i_dst_value,
   input  logic                        i_dst_filled,
   output logic                        o_disp_ready,
   input  logic                        i_cdb_valid,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_cdb_tag,
   input  logic [fcpu_pkg::DATA_W-1:0] i_cdb_data,
   output logic                        o_res_valid,
   output logic [fcpu_pkg::TAG_W-1:0]  o_res_tag,
   output logic [fcpu_pkg::DATA_W-1:0] o_res_data,
   input  logic                        i_res_ready,
   input  logic                        i_commit_valid,
   input  logic                        i_commit_invalidate,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_commit_tag,
   input  fcpu_pkg::opcode_t           i_commit_opcode,
   output logic                        o_pred_condition,
   output logic                        o_true_condition,
   output logic                        o_pred_miss
);

   localparam int OPS_W = fcpu_pkg::N_OPERANDS * fcpu_pkg::DATA_W;

   logic                          issue_valid;
   logic                          issue_ready;
   fcpu_pkg::opcode_t             issue_opcode;
   logic [fcpu_pkg::TAG_W-1:0]    issue_tag;
   logic [fcpu_pkg::DATA_W-1:0]   issue_a1;
   logic [fcpu_pkg::DATA_W-1:0]   issue_a2;
   logic [fcpu_pkg::DATA_W-1:0]   issue_dst;
   logic [fcpu_pkg::CALC_W-1:0]   calc;
   fcpu_pkg::opcode_t             calc_op;
   logic [fcpu_pkg::DATA_W-1:0]   calc_a1;
   logic [fcpu_pkg::DATA_W-1:0]   calc_a2;
   logic [(1 << fcpu_pkg::TAG_W)-1:0] pred_tab;
   logic [(1 << fcpu_pkg::TAG_W)-1:0] true_tab;

   reservation_station rs (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_flush        (o_pred_miss),
      .i_disp_valid   (i_disp_valid),
      .i_disp_opcode  (i_disp_opcode),
      .i_disp_tag     (i_disp_tag),
      .i_a1_tag       (i_a1_tag),
      .i_a1_value     (i_a1_value),
      .i_a1_filled    (i_a1_filled),
      .i_a2_tag       (i_a2_tag),
      .i_a2_value     (i_a2_value),
      .i_a2_filled    (i_a2_filled),
      .i_dst_tag      (i_dst_tag),
      .i_dst_value    (i_dst_value),
      .i_dst_filled   (i_dst_filled),
      .i_cdb_valid    (i_cdb_valid),
      .i_cdb_tag      (i_cdb_tag),
      .i_cdb_data     (i_cdb_data),
      .i_issue_ready  (issue_ready),
      .o_disp_ready   (o_disp_ready),
      .o_issue_valid  (issue_valid),
      .o_issue_opcode (issue_opcode),
      .o_issue_tag    (issue_tag),
      .o_issue_a1     (issue_a1),
      .o_issue_a2     (issue_a2),
      .o_issue_dst    (issue_dst)
   );

   fifo #(
      .DEPTH_W (0),
      .WIDTH   (fcpu_pkg::CALC_W)
   ) pre_calc_buf (
      .clk     (clk),
      .i_reset (i_reset),
      .i_flush (o_pred_miss),
      .i_data  ({issue_opcode, issue_tag, issue_a1, issue_a2, issue_dst}),
      .i_valid (issue_valid),
      .o_ready (issue_ready),
      .o_data  (calc),
      .o_valid (o_res_valid),
      .i_ready (i_res_ready)
   );

   assign calc_op    = fcpu_pkg::opcode_t'(calc[OPS_W + fcpu_pkg::TAG_W +: fcpu_pkg::INSTR_W]);
   assign o_res_tag  = calc[OPS_W +: fcpu_pkg::TAG_W];
   assign calc_a1    = calc[2 * fcpu_pkg::DATA_W +: fcpu_pkg::DATA_W];
   assign calc_a2    = calc[fcpu_pkg::DATA_W +: fcpu_pkg::DATA_W];
   // dst goes out as the result value
   assign o_res_data = calc[fcpu_pkg::DATA_W-1:0];

   // true condition, written as the result leaves the buffer
   always_ff @(posedge clk) begin
      if (i_reset) begin
         true_tab <= '0;
      end else if (o_res_valid && i_res_ready) begin
         case (calc_op)
            fcpu_pkg::I_BLT: true_tab[o_res_tag] <= $signed(calc_a1) < $signed(calc_a2);
            fcpu_pkg::I_BEQ: true_tab[o_res_tag] <= calc_a1 == calc_a2;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset || o_pred_miss) begin
         pred_tab <= '0;
      end else if (i_disp_valid && o_disp_ready) begin
         pred_tab[i_disp_tag] <= i_disp_pred;
      end
   end

   assign o_pred_condition = pred_tab[i_commit_tag];
   assign o_true_condition = true_tab[i_commit_tag];

   always_comb begin
      o_pred_miss = 1'b0;
      if (i_commit_valid && !i_commit_invalidate) begin
         case (i_commit_opcode)
            fcpu_pkg::I_JMPR: o_pred_miss = 1'b1;
            fcpu_pkg::I_BLT,
            fcpu_pkg::I_BEQ:  o_pred_miss = o_pred_condition ^ o_true_condition;
            default:          o_pred_miss = 1'b0;
         endcase
      end
   end

endmodule

// File: src/branch_subsystem.sv
module branch_subsystem (
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_disp_valid,
   input  fcpu_pkg::opcode_t           i_disp_opcode,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_disp_tag,
   input  logic                        i_disp_pred,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_a1_tag,
   input  logic [fcpu_pkg::DATA_W-1:0] i_a1_value,
   input  logic                        i_a1_filled,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_a2_tag,
   input  logic [fcpu_pkg::DATA_W-1:0] i_a2_value,
   input  logic                        i_a2_filled,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_dst_tag,
   input  logic [fcpu_pkg::DATA_W-1:0] i_dst_value,
   input  logic                        i_dst_filled,
   output logic                        o_disp_ready,
   input  logic                        i_alu_valid,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_alu_tag,
   input  logic [fcpu_pkg::DATA_W-1:0] i_alu_data,
   output logic                        o_alu_ready,
   input  logic                        i_commit_valid,
   input  logic                        i_commit_invalidate,
   input  logic [fcpu_pkg::TAG_W-1:0]  i_commit_tag,
   input  fcpu_pkg::opcode_t           i_commit_opcode,
   output logic                        o_pred_condition,
   output logic                        o_true_condition,
   output logic                        o_pred_miss,
   output logic                        o_cdb_valid,
   output logic [fcpu_pkg::TAG_W-1:0]  o_cdb_tag,
   output logic [fcpu_pkg::DATA_W-1:0] o_cdb_data
);

   logic                        br_valid;
   logic [fcpu_pkg::TAG_W-1:0]  br_tag;
   logic [fcpu_pkg::DATA_W-1:0] br_data;
   logic                        br_ready;

   // the cdb outputs double as the branch unit snoop inputs
   branch_unit bu (
      .clk                 (clk),
      .i_reset             (i_reset),
      .i_disp_valid        (i_disp_valid),
      .i_disp_opcode       (i_disp_opcode),
      .i_disp_tag          (i_disp_tag),
      .i_disp_pred         (i_disp_pred),
      .i_a1_tag            (i_a1_tag),
      .i_a1_value          (i_a1_value),
      .i_a1_filled         (i_a1_filled),
      .i_a2_tag            (i_a2_tag),
      .i_a2_value          (i_a2_value),
      .i_a2_filled         (i_a2_filled),
      .i_dst_tag           (i_dst_tag),
      .i_dst_value         (i_dst_value),
      .i_dst_filled        (i_dst_filled),
      .o_disp_ready        (o_disp_ready),
      .i_cdb_valid         (o_cdb_valid),
      .i_cdb_tag           (o_cdb_tag),
      .i_cdb_data          (o_cdb_data),
      .o_res_valid         (br_valid),
      .o_res_tag           (br_tag),
      .o_res_data          (br_data),
      .i_res_ready         (br_ready),
      .i_commit_valid      (i_commit_valid),
      .i_commit_invalidate (i_commit_invalidate),
      .i_commit_tag        (i_commit_tag),
      .i_commit_opcode     (i_commit_opcode),
      .o_pred_condition    (o_pred_condition),
      .o_true_condition    (o_true_condition),
      .o_pred_miss         (o_pred_miss)
   );

   cdb_arbiter arb (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_alu_valid (i_alu_valid),
      .i_alu_tag   (i_alu_tag),
      .i_alu_data  (i_alu_data),
      .o_alu_ready (o_alu_ready),
      .i_br_valid  (br_valid),
      .i_br_tag    (br_tag),
      .i_br_data   (br_data),
      .o_br_ready  (br_ready),
      .o_cdb_valid (o_cdb_valid),
      .o_cdb_tag   (o_cdb_tag),
      .o_cdb_data  (o_cdb_data)
   );

endmodule

// File: verif/tb_branch_subsystem.sv
module tb_branch_subsystem;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int TAG_W      = fcpu_pkg::TAG_W;
   localparam int DATA_W     = fcpu_pkg::DATA_W;
   localparam int N_TAGS     = 1 << TAG_W;
   localparam int N_MIXED    = 6;
   localparam int DISP_WAIT  = 50;
   localparam int ALU_WAIT   = 3;
   localparam int DRAIN_WAIT = 200;

   logic              clk = 1'b0;
   logic              i_reset;
   logic              i_disp_valid;
   fcpu_pkg::opcode_t i_disp_opcode;
   logic [TAG_W-1:0]  i_disp_tag;
   logic              i_disp_pred;
   logic [TAG_W-1:0]  i_a1_tag;
   logic [DATA_W-1:0] i_a1_value;
   logic              i_a1_filled;
   logic [TAG_W-1:0]  i_a2_tag;
   logic [DATA_W-1:0] i_a2_value;
   logic              i_a2_filled;
   logic [TAG_W-1:0]  i_dst_tag;
   logic [DATA_W-1:0] i_dst_value;
   logic              i_dst_filled;
   logic              o_disp_ready;
   logic              i_alu_valid;
   logic [TAG_W-1:0]  i_alu_tag;
   logic [DATA_W-1:0] i_alu_data;
   logic              o_alu_ready;
   logic              i_commit_valid;
   logic              i_commit_invalidate;
   logic [TAG_W-1:0]  i_commit_tag;
   fcpu_pkg::opcode_t i_commit_opcode;
   logic              o_pred_condition;
   logic              o_true_condition;
   logic              o_pred_miss;
   logic              o_cdb_valid;
   logic [TAG_W-1:0]  o_cdb_tag;
   logic [DATA_W-1:0] o_cdb_data;

   logic [15:0]       lfsr = 16'd42;
   int                cycle = 0;
   logic [TAG_W-1:0]  exp_tag [$];
   logic [DATA_W-1:0] exp_val [$];
   int                seen_cycle [N_TAGS];
   logic              pred_model [N_TAGS];
   logic              true_model [N_TAGS];

   fcpu_pkg::opcode_t mix_op   [N_MIXED];
   logic              mix_pred [N_MIXED];
   logic [DATA_W-1:0] mix_a1   [N_MIXED];
   logic [DATA_W-1:0] mix_a2   [N_MIXED];
   logic [DATA_W-1:0] mix_dst  [N_MIXED];
   logic [DATA_W-1:0] mix_alu  [N_MIXED];
   logic              mix_gap  [N_MIXED];

   branch_subsystem DUT (.*);

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic true_cond(input fcpu_pkg::opcode_t op,
                                      input logic [DATA_W-1:0] a1,
                                      input logic [DATA_W-1:0] a2);
      case (op)
         fcpu_pkg::I_BLT: return $signed(a1) < $signed(a2);
         fcpu_pkg::I_BEQ: return a1 == a2;
         default:         return 1'b0;
      endcase
   endfunction

   function automatic logic miss_expected(input fcpu_pkg::opcode_t op, input logic pred,
                                          input logic truec, input logic inval);
      if (inval) begin
         return 1'b0;
      end
      case (op)
         fcpu_pkg::I_JMPR: return 1'b1;
         fcpu_pkg::I_BLT,
         fcpu_pkg::I_BEQ:  return pred != truec;
         default:          return 1'b0;
      endcase
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic draw(input int nbits, output logic [DATA_W-1:0] v);
      v = '0;
      for (int b = 0; b < nbits; b++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[DATA_W-2:0], lfsr[0]};
      end
   endtask

   task automatic random_branch(output fcpu_pkg::opcode_t op, output logic pred,
                                output logic [DATA_W-1:0] a1, output logic [DATA_W-1:0] a2,
                                output logic [DATA_W-1:0] dst);
      logic [DATA_W-1:0] r;
      draw(1, r);
      op = r[0] ? fcpu_pkg::I_BEQ : fcpu_pkg::I_BLT;
      draw(1, r);
      pred = r[0];
      draw(DATA_W, a1);
      // equal operands often enough for BEQ to resolve taken
      draw(1, r);
      if (r[0]) begin
         a2 = a1;
      end else begin
         draw(DATA_W, a2);
      end
      draw(DATA_W, dst);
   endtask

   task automatic expect_result(input logic [TAG_W-1:0] tag, input logic [DATA_W-1:0] data);
      exp_tag.push_back(tag);
      exp_val.push_back(data);
   endtask

   // a1 may wait on wait_tag and then takes the value a1
   task automatic dispatch(input fcpu_pkg::opcode_t op, input logic [TAG_W-1:0] tag,
                           input logic pred, input logic a1_wait,
                           input logic [TAG_W-1:0] wait_tag, input logic [DATA_W-1:0] a1,
                           input logic [DATA_W-1:0] a2, input logic [DATA_W-1:0] dst,
                           input logic resolves, output int acc);
      logic ready;
      @(posedge clk);
      i_disp_valid  <= 1'b1;
      i_disp_opcode <= op;
      i_disp_tag    <= tag;
      i_disp_pred   <= pred;
      i_a1_tag      <= wait_tag;
      i_a1_value    <= a1_wait ? '0 : a1;
      i_a1_filled   <= !a1_wait;
      i_a2_value    <= a2;
      i_a2_filled   <= 1'b1;
      i_dst_value   <= dst;
      i_dst_filled  <= 1'b1;
      ready = 1'b0;
      for (int n = 0; n < DISP_WAIT && !ready; n++) begin
         @(negedge clk);
         ready = o_disp_ready;
      end
      if (!ready) begin
         abort_run($sformatf("dispatch of tag %0d was never accepted", tag));
      end
      acc = cycle;
      pred_model[tag] = pred;
      if (resolves) begin
         true_model[tag] = true_cond(op, a1, a2);
         expect_result(tag, dst);
      end
      @(posedge clk);
      i_disp_valid <= 1'b0;
   endtask

   task automatic offer_alu(input logic [TAG_W-1:0] tag, input logic [DATA_W-1:0] data);
      logic ready;
      @(posedge clk);
      i_alu_valid <= 1'b1;
      i_alu_tag   <= tag;
      i_alu_data  <= data;
      expect_result(tag, data);
      ready = 1'b0;
      for (int n = 0; n < ALU_WAIT && !ready; n++) begin
         @(negedge clk);
         ready = o_alu_ready;
      end
      if (!ready) begin
         abort_run($sformatf("ALU result tag %0d starved by the arbiter", tag));
      end
      @(posedge clk);
      i_alu_valid <= 1'b0;
   endtask

   task automatic wait_drained();
      for (int n = 0; n < DRAIN_WAIT && exp_tag.size() != 0; n++) begin
         @(posedge clk);
      end
      if (exp_tag.size() != 0) begin
         abort_run($sformatf("%0d results never appeared on the CDB", exp_tag.size()));
      end
   endtask

   task automatic commit_check(input logic [TAG_W-1:0] tag, input fcpu_pkg::opcode_t op,
                               input logic inval);
      logic e_pred;
      logic e_true;
      logic e_miss;
      e_pred = pred_model[tag];
      e_true = true_model[tag];
      e_miss = miss_expected(op, e_pred, e_true, inval);
      @(posedge clk);
      i_commit_valid      <= 1'b1;
      i_commit_tag        <= tag;
      i_commit_opcode     <= op;
      i_commit_invalidate <= inval;
      @(negedge clk);
      assert (o_pred_condition === e_pred) else
         abort_run($sformatf("ERROR %0t o_pred_condition tag %0d expected %0b got %0b",
                             $time, tag, e_pred, o_pred_condition));
      assert (o_true_condition === e_true) else
         abort_run($sformatf("ERROR %0t o_true_condition tag %0d expected %0b got %0b",
                             $time, tag, e_true, o_true_condition));
      assert (o_pred_miss === e_miss) else
         abort_run($sformatf("ERROR %0t o_pred_miss tag %0d expected %0b got %0b",
                             $time, tag, e_miss, o_pred_miss));
      @(posedge clk);
      i_commit_valid <= 1'b0;
      // a miss clears the prediction table at this edge
      if (e_miss) begin
         for (int t = 0; t < N_TAGS; t++) begin
            pred_model[t] = 1'b0;
         end
      end
   endtask

   // every broadcast must match one outstanding result in any order
   always @(negedge clk) begin : cdb_check
      int idx;
      if (!i_reset && o_cdb_valid === 1'b1) begin
         idx = -1;
         for (int i = 0; i < exp_tag.size(); i++) begin
            if (idx < 0 && exp_tag[i] == o_cdb_tag) begin
               idx = i;
            end
         end
         assert (idx >= 0) else
            abort_run($sformatf("ERROR %0t o_cdb_tag expected no broadcast got tag %0d",
                                $time, o_cdb_tag));
         assert (o_cdb_data === exp_val[idx]) else
            abort_run($sformatf("ERROR %0t o_cdb_data tag %0d expected %h got %h",
                                $time, o_cdb_tag, exp_val[idx], o_cdb_data));
         seen_cycle[o_cdb_tag] = cycle;
         exp_tag.delete(idx);
         exp_val.delete(idx);
      end
   end

   initial begin : stimulus
      fcpu_pkg::opcode_t op;
      logic              pred;
      logic [DATA_W-1:0] a1;
      logic [DATA_W-1:0] a2;
      logic [DATA_W-1:0] dst;
      logic [DATA_W-1:0] r;
      int                acc;
      int                acc_mix;
      i_reset             = 1'b1;
      i_disp_valid        = 1'b0;
      i_disp_opcode       = fcpu_pkg::I_NOP;
      i_disp_tag          = '0;
      i_disp_pred         = 1'b0;
      i_a1_tag            = '0;
      i_a1_value          = '0;
      i_a1_filled         = 1'b0;
      i_a2_tag            = '0;
      i_a2_value          = '0;
      i_a2_filled         = 1'b0;
      i_dst_tag           = '0;
      i_dst_value         = '0;
      i_dst_filled        = 1'b0;
      i_alu_valid         = 1'b0;
      i_alu_tag           = '0;
      i_alu_data          = '0;
      i_commit_valid      = 1'b0;
      i_commit_invalidate = 1'b0;
      i_commit_tag        = '0;
      i_commit_opcode     = fcpu_pkg::I_NOP;
      for (int t = 0; t < N_TAGS; t++) begin
         seen_cycle[t] = 0;
         pred_model[t] = 1'b0;
         true_model[t] = 1'b0;
      end
      repeat (3) @(posedge clk);
      i_reset <= 1'b0;

      // filled branches on an idle CDB
      for (int i = 0; i < 4; i++) begin
         random_branch(op, pred, a1, a2, dst);
         dispatch(op, TAG_W'(i), pred, 1'b0, '0, a1, a2, dst, 1'b1, acc);
         wait_drained();
         assert (seen_cycle[i] - acc == 3) else
            abort_run($sformatf("ERROR %0t o_cdb_valid latency tag %0d expected 3 got %0d",
                                $time, i, seen_cycle[i] - acc));
      end

      // branches and ALU results offered together
      for (int i = 0; i < N_MIXED; i++) begin
         random_branch(mix_op[i], mix_pred[i], mix_a1[i], mix_a2[i], mix_dst[i]);
         draw(DATA_W, mix_alu[i]);
         draw(1, r);
         mix_gap[i] = r[0];
      end
      fork
         begin
            for (int i = 0; i < N_MIXED; i++) begin
               dispatch(mix_op[i], TAG_W'(i), mix_pred[i], 1'b0, '0, mix_a1[i], mix_a2[i],
                        mix_dst[i], 1'b1, acc_mix);
            end
         end
         begin
            for (int i = 0; i < N_MIXED; i++) begin
               if (mix_gap[i]) begin
                  @(posedge clk);
               end
               offer_alu(TAG_W'(8 + i), mix_alu[i]);
            end
         end
      join
      wait_drained();

      // commit decode with about one commit in four invalidated
      for (int i = 0; i < N_MIXED; i++) begin
         draw(2, r);
         commit_check(TAG_W'(i), mix_op[i], &r[1:0]);
      end
      commit_check(TAG_W'(0), fcpu_pkg::I_JMP, 1'b0);
      commit_check(TAG_W'(1), fcpu_pkg::I_JMPR, 1'b1);

      // a1 of tag 6 comes from ALU tag 14
      random_branch(op, pred, a1, a2, dst);
      dispatch(op, TAG_W'(6), pred, 1'b1, TAG_W'(14), a1, a2, dst, 1'b1, acc);
      offer_alu(TAG_W'(14), a1);
      wait_drained();
      assert (seen_cycle[6] > seen_cycle[14]) else
         abort_run("branch tag 6 was broadcast before the ALU result it waited on");
      commit_check(TAG_W'(6), op, 1'b0);

      // tag 7 predicts taken and stays waiting on tag 15 across a mispredicted jump
      random_branch(op, pred, a1, a2, dst);
      dispatch(op, TAG_W'(7), 1'b1, 1'b1, TAG_W'(15), a1, a2, dst, 1'b0, acc);
      commit_check(TAG_W'(2), fcpu_pkg::I_JMPR, 1'b0);
      offer_alu(TAG_W'(15), a1);
      wait_drained();
      repeat (12) @(posedge clk);
      for (int t = 0; t < N_TAGS; t++) begin
         commit_check(TAG_W'(t), fcpu_pkg::I_NOP, 1'b0);
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

// File: branch_subsystem.f
common/fcpu_pkg.sv
src/fifo.sv
src/cdb_arbiter.sv
branch_unit/reservation_station.sv
branch_unit/branch_unit.sv
src/branch_subsystem.sv
verif/tb_branch_subsystem.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_branch_subsystem \
   --Mdir obj_dir \
   -f branch_subsystem.f

./obj_dir/Vtb_branch_subsystem
